/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    typedef logic [31:0]  addr_t;      // Byte address
    typedef logic [31:0]  word_t;      // One lane, one bus beat
    typedef logic [127:0] vec_t;       // Four lanes
    typedef logic [4:0]   reg_idx_t;
    typedef logic [1:0]   lane_idx_t;

    typedef enum logic [1:0] {
        VEC_UNIT    = 2'd0,
        VEC_STRIDE  = 2'd1,
        VEC_INDEXED = 2'd2
    } vec_mode_e;

    localparam int LANES          = 4;
    localparam int VEC_ALIGN_BITS = 4;  // 16-byte vector base

    // Address of one lane of a vector access
    function automatic addr_t lane_addr(input addr_t base, input vec_mode_e mode,
                                        input addr_t stride, input vec_t index,
                                        input lane_idx_t lane);
        case (mode)
            VEC_STRIDE:  return base + stride * addr_t'(lane);
            VEC_INDEXED: return base + index[lane * $bits(word_t) +: $bits(word_t)];
            default:     return base + addr_t'(lane) * addr_t'(4); // Unit and reserved
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/lsu_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One shaped load or store on its way to the beat sequencer
interface lsu_req_if;

    logic                req_valid;
    logic                req_is_load;
    logic                req_is_vector;
    lsu_pkg::addr_t      req_addr;     // Aligned base for vectors
    lsu_pkg::vec_t       req_wdata;
    lsu_pkg::reg_idx_t   req_rd;
    lsu_pkg::vec_mode_e  req_mode;
    lsu_pkg::addr_t      req_stride;
    lsu_pkg::vec_t       req_index;
    logic                req_ready;    // High when the first beat is taken

    modport shaper (
        output req_valid, req_is_load, req_is_vector, req_addr, req_wdata,
               req_rd, req_mode, req_stride, req_index,
        input  req_ready
    );

    modport sequencer (
        input  req_valid, req_is_load, req_is_vector, req_addr, req_wdata,
               req_rd, req_mode, req_stride, req_index,
        output req_ready
    );

endinterface

`default_nettype wire

/* logic/lsu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  logic                is_vector,
    input  logic                is_store,
    input  lsu_pkg::vec_mode_e  vec_mode,
    input  lsu_pkg::addr_t      vec_stride,
    input  lsu_pkg::vec_t       vec_index,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::vec_t       write_data,
    input  lsu_pkg::reg_idx_t   dest_reg_idx,
    input  logic                wb_valid,
    input  logic                wb_is_vector,
    lsu_req_if.shaper           req,
    output logic                stall_pipeline,
    output logic                scalar_wait
);

    localparam int WORD_W = $bits(lsu_pkg::word_t);
    localparam lsu_pkg::addr_t ALIGN_MASK =
        ~lsu_pkg::addr_t'((1 << lsu_pkg::VEC_ALIGN_BITS) - 1);

    typedef enum logic {
        DEC_IDLE,
        DEC_WAIT_SCALAR
    } dec_state_e;

    dec_state_e state;
    logic       scalar_load;
    logic       scalar_wb;

    assign scalar_load = !is_vector && !is_store;
    assign scalar_wb   = wb_valid && !wb_is_vector;  // Only one scalar can be open
    assign scalar_wait = (state == DEC_WAIT_SCALAR);

    // ----------------------------------------
    // Request shaping
    // ----------------------------------------
    assign req.req_valid     = valid_in && !scalar_wait;  // Held load must not reissue
    assign req.req_is_load   = !is_store;
    assign req.req_is_vector = is_vector;
    assign req.req_addr      = is_vector ? (addr & ALIGN_MASK) : addr;
    assign req.req_wdata     = is_vector ? write_data
                                         : lsu_pkg::vec_t'(write_data[WORD_W-1:0]);
    assign req.req_rd        = dest_reg_idx;
    assign req.req_mode      = vec_mode;
    assign req.req_stride    = vec_stride;
    assign req.req_index     = vec_index;

    // Low in the writeback cycle so the pipeline can retire the held load
    assign stall_pipeline = (scalar_wait && !scalar_wb)
                         || (req.req_valid && (!req.req_ready || scalar_load));

    // ----------------------------------------
    // Blocking scalar load tracking
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DEC_IDLE;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (req.req_valid && req.req_ready && scalar_load) begin
                        state <= DEC_WAIT_SCALAR;
                    end
                end
                DEC_WAIT_SCALAR: begin
                    if (scalar_wb) begin
                        state <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_beat_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_beat_seq (
    input  logic               clk,
    input  logic               rst_n,
    lsu_req_if.sequencer       req,
    output logic               global_req_valid,
    output logic               global_req_is_load,
    output lsu_pkg::addr_t     global_req_addr,
    output lsu_pkg::word_t     global_req_wdata,
    output lsu_pkg::reg_idx_t  global_req_rd,
    input  logic               global_req_ready,
    output logic               expect_push,
    output logic               expect_vector,
    output logic               seq_active
);

    localparam int WORD_W = $bits(lsu_pkg::word_t);

    typedef enum logic {
        SEQ_IDLE,
        SEQ_BEATS
    } seq_state_e;

    seq_state_e          state;
    lsu_pkg::lane_idx_t  lane_q;     // Beat being presented
    lsu_pkg::addr_t      base_q;
    lsu_pkg::vec_t       data_q;
    lsu_pkg::vec_mode_e  mode_q;
    lsu_pkg::addr_t      stride_q;
    lsu_pkg::vec_t       index_q;
    logic                is_load_q;
    lsu_pkg::reg_idx_t   rd_q;
    logic                accept;
    logic                last_beat;

    assign req.req_ready = (state == SEQ_IDLE) && global_req_ready;
    assign accept        = req.req_valid && req.req_ready;
    assign last_beat     = (lane_q == lsu_pkg::lane_idx_t'(lsu_pkg::LANES - 1));

    assign expect_push   = accept && req.req_is_load;
    assign expect_vector = req.req_is_vector;
    assign seq_active    = (state != SEQ_IDLE);

    // ----------------------------------------
    // Global port drive
    // ----------------------------------------
    always_comb begin
        if (state == SEQ_BEATS) begin
            global_req_valid   = 1'b1;
            global_req_is_load = is_load_q;
            global_req_addr    = lsu_pkg::lane_addr(base_q, mode_q, stride_q, index_q, lane_q);
            global_req_wdata   = data_q[lane_q * WORD_W +: WORD_W];
            global_req_rd      = rd_q;
        end else begin
            // Scalar or beat 0 straight from decode
            global_req_valid   = req.req_valid;
            global_req_is_load = req.req_is_load;
            global_req_addr    = req.req_is_vector
                ? lsu_pkg::lane_addr(req.req_addr, req.req_mode, req.req_stride,
                                     req.req_index, lsu_pkg::lane_idx_t'(0))
                : req.req_addr;
            global_req_wdata   = req.req_wdata[WORD_W-1:0];
            global_req_rd      = req.req_rd;
        end
    end

    // ----------------------------------------
    // Beat sequencing
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= SEQ_IDLE;
            lane_q <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (accept && req.req_is_vector) begin
                        state  <= SEQ_BEATS;
                        lane_q <= lsu_pkg::lane_idx_t'(1);
                    end
                end
                SEQ_BEATS: begin
                    if (global_req_ready) begin  // Hold beat under back-pressure
                        lane_q <= lane_q + lsu_pkg::lane_idx_t'(1);
                        if (last_beat) begin
                            state <= SEQ_IDLE;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Vector context for beats 1 to 3
    always_ff @(posedge clk) begin
        if (accept) begin
            base_q    <= req.req_addr;
            data_q    <= req.req_wdata;
            mode_q    <= req.req_mode;
            stride_q  <= req.req_stride;
            index_q   <= req.req_index;
            is_load_q <= req.req_is_load;
            rd_q      <= req.req_rd;
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_resp_collect.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_resp_collect #(
    parameter int EXPECT_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               expect_push,
    input  logic               expect_vector,
    input  logic               global_resp_valid,
    input  lsu_pkg::reg_idx_t  global_resp_rd,
    input  lsu_pkg::word_t     global_resp_data,
    output logic               wb_valid,
    output logic               wb_is_vector,
    output lsu_pkg::reg_idx_t  wb_reg_idx,
    output lsu_pkg::vec_t      wb_data,
    output logic               expect_empty
);

    localparam int PTR_W  = $clog2(EXPECT_DEPTH);
    localparam int WORD_W = $bits(lsu_pkg::word_t);

    // ----------------------------------------
    // Expected-response queue
    // ----------------------------------------
    logic                kind_q [EXPECT_DEPTH];  // 1 for a vector load
    logic [PTR_W:0]      wr_ptr;                 // Extra bit tells full from empty
    logic [PTR_W:0]      rd_ptr;
    logic                head_vector;
    logic                resp_hit;
    logic                pop;

    assign expect_empty = (wr_ptr == rd_ptr);
    assign head_vector  = kind_q[rd_ptr[PTR_W-1:0]];
    assign resp_hit     = global_resp_valid && !expect_empty;

    always_ff @(posedge clk) begin
        if (expect_push) begin
            kind_q[wr_ptr[PTR_W-1:0]] <= expect_vector;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (expect_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Vector reassembly
    // ----------------------------------------
    lsu_pkg::lane_idx_t  lane_cnt;
    logic                last_lane;
    lsu_pkg::reg_idx_t   vec_rd_q;     // Register index seen on beat 0
    lsu_pkg::word_t      gather_q [lsu_pkg::LANES-1];
    lsu_pkg::vec_t       assembled;

    assign last_lane = (lane_cnt == lsu_pkg::lane_idx_t'(lsu_pkg::LANES - 1));
    assign pop       = resp_hit && (!head_vector || last_lane);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_cnt <= '0;
        end else if (resp_hit && head_vector) begin
            lane_cnt <= lane_cnt + lsu_pkg::lane_idx_t'(1);  // Wraps after last lane
        end
    end

    always_ff @(posedge clk) begin
        if (resp_hit && head_vector && !last_lane) begin
            gather_q[lane_cnt] <= global_resp_data;
            if (lane_cnt == '0) begin
                vec_rd_q <= global_resp_rd;
            end
        end
    end

    // Last lane goes straight from the bus
    always_comb begin
        for (int i = 0; i < lsu_pkg::LANES - 1; i++) begin
            assembled[i*WORD_W +: WORD_W] = gather_q[i];
        end
        assembled[(lsu_pkg::LANES-1)*WORD_W +: WORD_W] = global_resp_data;
    end

    // ----------------------------------------
    // Writeback
    // ----------------------------------------
    assign wb_valid     = pop;
    assign wb_is_vector = head_vector;
    assign wb_reg_idx   = head_vector ? vec_rd_q : global_resp_rd;
    assign wb_data      = head_vector ? assembled : lsu_pkg::vec_t'(global_resp_data);

endmodule

`default_nettype wire

/* logic/lsu_global.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_global #(
    parameter int EXPECT_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    // Pipeline
    input  logic                valid_in,
    input  logic                is_vector,
    input  logic                is_store,
    input  lsu_pkg::vec_mode_e  vec_mode,
    input  lsu_pkg::addr_t      vec_stride,
    input  lsu_pkg::vec_t       vec_index,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::vec_t       write_data,
    input  lsu_pkg::reg_idx_t   dest_reg_idx,
    output logic                stall_pipeline,
    output logic                busy,
    // Global memory port
    output logic                global_req_valid,
    output logic                global_req_is_load,
    output lsu_pkg::addr_t      global_req_addr,
    output lsu_pkg::word_t      global_req_wdata,
    output lsu_pkg::reg_idx_t   global_req_rd,
    input  logic                global_req_ready,
    input  logic                global_resp_valid,
    input  lsu_pkg::reg_idx_t   global_resp_rd,
    input  lsu_pkg::word_t      global_resp_data,
    // Writeback
    output logic                wb_valid,
    output logic                wb_is_vector,
    output lsu_pkg::reg_idx_t   wb_reg_idx,
    output lsu_pkg::vec_t       wb_data
);

    logic scalar_wait;
    logic seq_active;
    logic expect_push;
    logic expect_vector;
    logic expect_empty;

    lsu_req_if req_bus ();

    lsu_decode decode_i (
        .clk, .rst_n, .valid_in, .is_vector, .is_store, .vec_mode, .vec_stride,
        .vec_index, .addr, .write_data, .dest_reg_idx, .wb_valid, .wb_is_vector,
        .req            (req_bus),
        .stall_pipeline,
        .scalar_wait
    );

    lsu_beat_seq beat_seq_i (
        .clk, .rst_n,
        .req            (req_bus),
        .global_req_valid, .global_req_is_load, .global_req_addr,
        .global_req_wdata, .global_req_rd, .global_req_ready,
        .expect_push, .expect_vector, .seq_active
    );

    lsu_resp_collect #(
        .EXPECT_DEPTH   (EXPECT_DEPTH)
    ) resp_collect_i (
        .clk, .rst_n, .expect_push, .expect_vector,
        .global_resp_valid, .global_resp_rd, .global_resp_data,
        .wb_valid, .wb_is_vector, .wb_reg_idx, .wb_data, .expect_empty
    );

    // Anything in flight or waiting at the request stage
    assign busy = scalar_wait
               || seq_active
               || (req_bus.req_valid && !req_bus.req_ready)
               || !expect_empty;

endmodule

`default_nettype wire

/* test/lsu_global_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_global_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            valid_in,
    input logic            is_vector,
    input logic            is_store,
    input logic            stall_pipeline,
    input logic            global_req_valid,
    input logic            global_req_is_load,
    input logic            global_req_ready,
    input lsu_pkg::addr_t  global_req_addr,
    input lsu_pkg::word_t  global_req_wdata,
    input logic            wb_valid,
    input logic            wb_is_vector
);

    logic scalar_load_in;
    logic scalar_wb;
    logic scalar_sent;     // A load beat went out while the scalar was held

    assign scalar_load_in = valid_in && !is_vector && !is_store;
    assign scalar_wb      = wb_valid && !wb_is_vector;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scalar_sent <= 1'b0;
        end else if (scalar_load_in && !stall_pipeline) begin
            scalar_sent <= 1'b0;  // Released to the pipeline
        end else if (scalar_load_in && global_req_valid && global_req_ready
                     && global_req_is_load) begin
            scalar_sent <= 1'b1;
        end
    end

    // Nothing leaves the unit while reset is held
    reset_quiet: assert property (@(posedge clk) !rst_n |-> (!global_req_valid && !wb_valid))
        else $error("global_req_valid or wb_valid high during reset");

    beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (global_req_valid && !global_req_ready) |=> (global_req_valid
            && $stable(global_req_addr) && $stable(global_req_wdata)
            && $stable(global_req_is_load)))
        else $error("refused beat changed before it was accepted");

    // A held scalar load is only released after its beat went out, in its writeback cycle
    scalar_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (scalar_load_in && !stall_pipeline) |-> (scalar_sent && scalar_wb))
        else $error("stall_pipeline fell before the scalar load was sent and written back");

endmodule

`default_nettype wire

/* test/lsu_global_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_global_tb;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 8;
    localparam int          N_RANDOM     = 200;
    localparam int          N_DIRECTED   = 8;
    localparam int          DRAIN_LIMIT  = 6;   // Cycles for busy to fall
    localparam longint      TIMEOUT_NS   = longint'(N_RANDOM + N_DIRECTED) * 40 * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED    = 32'he860f5cd;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam logic [31:0] WINDOW_BASE  = 32'h0000_1000;

    typedef struct {
        logic                is_vector;
        logic                is_store;
        lsu_pkg::vec_mode_e  mode;
        lsu_pkg::addr_t      stride;
        lsu_pkg::vec_t       index;
        lsu_pkg::addr_t      addr;
        lsu_pkg::vec_t       wdata;
        lsu_pkg::reg_idx_t   rd;
    } op_t;

    typedef struct {
        lsu_pkg::addr_t      addr;
        lsu_pkg::word_t      data;
        logic                is_load;
        logic                is_vector;
        lsu_pkg::reg_idx_t   rd;
        int                  lane;
    } beat_t;

    typedef struct {
        logic                is_vector;
        lsu_pkg::reg_idx_t   rd;
        lsu_pkg::vec_t       data;
    } wb_t;

    typedef struct {
        longint              due;
        lsu_pkg::reg_idx_t   rd;
        lsu_pkg::word_t      data;
    } resp_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                valid_in;
    logic                is_vector;
    logic                is_store;
    lsu_pkg::vec_mode_e  vec_mode;
    lsu_pkg::addr_t      vec_stride;
    lsu_pkg::vec_t       vec_index;
    lsu_pkg::addr_t      addr;
    lsu_pkg::vec_t       write_data;
    lsu_pkg::reg_idx_t   dest_reg_idx;
    logic                stall_pipeline;
    logic                busy;
    logic                global_req_valid;
    logic                global_req_is_load;
    lsu_pkg::addr_t      global_req_addr;
    lsu_pkg::word_t      global_req_wdata;
    lsu_pkg::reg_idx_t   global_req_rd;
    logic                global_req_ready;
    logic                global_resp_valid;
    lsu_pkg::reg_idx_t   global_resp_rd;
    lsu_pkg::word_t      global_resp_data;
    logic                wb_valid;
    logic                wb_is_vector;
    lsu_pkg::reg_idx_t   wb_reg_idx;
    lsu_pkg::vec_t       wb_data;

    logic [31:0]         lfsr;
    lsu_pkg::word_t      mem [lsu_pkg::addr_t];  // Model memory
    op_t                 pend_ops [$];
    beat_t               exp_beats [$];
    wb_t                 exp_wbs [$];
    resp_t               resp_q [$];
    op_t                 cur_op;
    logic                cur_valid;
    logic                random_ready;
    lsu_pkg::vec_t       gather;
    longint              cycle;
    longint              last_due;
    int                  errors;
    int                  checks;
    int                  tests;
    int                  loads_issued;
    int                  wb_count;

    lsu_global #(.EXPECT_DEPTH(8)) lsu_global_i (.*);

    bind lsu_global lsu_global_asserts lsu_global_asserts_i (
        .clk, .rst_n, .valid_in, .is_vector, .is_store, .stall_pipeline,
        .global_req_valid, .global_req_is_load, .global_req_ready,
        .global_req_addr, .global_req_wdata, .wb_valid, .wb_is_vector
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish in the time allowed for its operations");
        $display("** FAIL **");
        $finish;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic lsu_pkg::word_t mem_read(input lsu_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return ~a ^ {a[15:0], a[31:16]};  // Unwritten words
    endfunction

    function automatic lsu_pkg::addr_t model_lane_addr(input op_t op, input int lane);
        lsu_pkg::addr_t base;
        base = op.addr & ~32'hf;
        case (op.mode)
            lsu_pkg::VEC_STRIDE:  return base + op.stride * 32'(lane);
            lsu_pkg::VEC_INDEXED: return base + op.index[lane*32 +: 32];
            default:              return base + 32'(lane) * 32'd4;
        endcase
    endfunction

    function automatic op_t make_op(input logic vec, input logic store,
                                    input lsu_pkg::vec_mode_e mode, input lsu_pkg::addr_t stride,
                                    input lsu_pkg::vec_t index, input lsu_pkg::addr_t a,
                                    input lsu_pkg::vec_t wdata, input lsu_pkg::reg_idx_t rd);
        op_t op;
        op.is_vector = vec;
        op.is_store  = store;
        op.mode      = mode;
        op.stride    = stride;
        op.index     = index;
        op.addr      = a;
        op.wdata     = wdata;
        op.rd        = rd;
        return op;
    endfunction

    function automatic op_t random_op();
        op_t op;
        op.is_vector = lfsr_take(1);
        op.is_store  = lfsr_take(1);
        op.mode      = lsu_pkg::vec_mode_e'(lfsr_take(8) % 3);
        op.stride    = lfsr_take(4) << 2;
        for (int i = 0; i < 4; i++) begin
            op.index[i*32 +: 32] = lfsr_take(6) << 2;
            op.wdata[i*32 +: 32] = lfsr_take(32);
        end
        op.addr = WINDOW_BASE + (lfsr_take(8) << 2);
        op.rd   = lfsr_take(5);
        return op;
    endfunction

    function automatic void expect_beats(input op_t op);
        beat_t b;
        for (int lane = 0; lane < (op.is_vector ? lsu_pkg::LANES : 1); lane++) begin
            b.addr      = op.is_vector ? model_lane_addr(op, lane) : op.addr;
            b.data      = op.wdata[lane*32 +: 32];
            b.is_load   = !op.is_store;
            b.is_vector = op.is_vector;
            b.rd        = op.rd;
            b.lane      = lane;
            exp_beats.push_back(b);
        end
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // ----------------------------------------
    // Memory model and reference
    // ----------------------------------------
    task automatic accept_beat();
        beat_t b;
        resp_t r;
        wb_t   w;
        if (exp_beats.size() == 0) begin
            report_error("a beat appeared on the global port with no request outstanding");
            return;
        end
        b = exp_beats.pop_front();
        check_value("global_req_addr", global_req_addr, b.addr);
        check_value("global_req_is_load", global_req_is_load, b.is_load);
        if (!b.is_load) begin
            check_value("global_req_wdata", global_req_wdata, b.data);
            mem[global_req_addr] = global_req_wdata;
            return;
        end
        check_value("global_req_rd", global_req_rd, b.rd);
        r.due    = cycle + 1 + longint'(lfsr_take(2));
        r.due    = (r.due > last_due) ? r.due : last_due + 1;  // One word per cycle
        last_due = r.due;
        r.rd     = global_req_rd;
        r.data   = mem_read(global_req_addr);
        resp_q.push_back(r);
        gather[b.lane*32 +: 32] = mem_read(b.addr);
        if (!b.is_vector || b.lane == lsu_pkg::LANES - 1) begin
            w.is_vector = b.is_vector;
            w.rd        = b.rd;
            w.data      = b.is_vector ? gather : lsu_pkg::vec_t'(mem_read(b.addr));
            exp_wbs.push_back(w);
        end
    endtask

    task automatic check_writeback();
        wb_t w;
        wb_count++;
        if (exp_wbs.size() == 0) begin
            report_error("writeback seen with no load outstanding");
            return;
        end
        w = exp_wbs.pop_front();
        check_value("wb_is_vector", wb_is_vector, w.is_vector);
        check_value("wb_reg_idx", wb_reg_idx, w.rd);
        check_value("wb_data", wb_data, w.data);
    endtask

    // Drive on the falling edge, sample a quarter period later
    task automatic run_cycle();
        logic resp_now;
        @(negedge clk);
        if (!cur_valid && pend_ops.size() > 0) begin
            cur_op    = pend_ops.pop_front();
            cur_valid = 1'b1;
            expect_beats(cur_op);
            if (!cur_op.is_store) begin
                loads_issued++;
            end
        end
        valid_in         = cur_valid;
        is_vector        = cur_op.is_vector;
        is_store         = cur_op.is_store;
        vec_mode         = cur_op.mode;
        vec_stride       = cur_op.stride;
        vec_index        = cur_op.index;
        addr             = cur_op.addr;
        write_data       = cur_op.wdata;
        dest_reg_idx     = cur_op.rd;
        global_req_ready = random_ready ? (lfsr_take(2) != 0) : 1'b1;
        resp_now         = (resp_q.size() > 0) && (resp_q[0].due <= cycle);
        global_resp_valid = resp_now;
        if (resp_now) begin
            global_resp_rd   = resp_q[0].rd;
            global_resp_data = resp_q[0].data;
        end
        #(CLK_PERIOD / 4);
        if (global_req_valid && global_req_ready) begin
            accept_beat();
        end
        if (wb_valid) begin
            check_writeback();
        end
        if (valid_in && !stall_pipeline) begin
            if (!cur_op.is_store) begin
                if (!cur_op.is_vector && !(wb_valid && !wb_is_vector)) begin
                    report_error("stall_pipeline fell before the scalar load wrote back");
                end
            end
            cur_valid = 1'b0;
        end
        if (resp_now) begin
            void'(resp_q.pop_front());
        end
        cycle++;
    endtask

    task automatic run_ops();
        int idle;
        idle = 0;
        while (idle < DRAIN_LIMIT) begin
            run_cycle();
            if (pend_ops.size() == 0 && !cur_valid && exp_beats.size() == 0
                    && resp_q.size() == 0) begin
                if (!busy) begin
                    if (exp_wbs.size() != 0) begin
                        report_error("a load finished without its writeback");
                    end
                    return;
                end
                idle++;
            end
        end
        report_error("busy stayed high after the last response");
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("Test %0d %s done with %0d errors", tests, name, errors - errs_before);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int errs;
        lfsr         = LFSR_SEED;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        loads_issued = 0;
        wb_count     = 0;
        cycle        = 0;
        last_due     = 0;
        cur_valid    = 1'b0;
        random_ready = 1'b0;
        cur_op       = make_op(1'b0, 1'b0, lsu_pkg::VEC_UNIT, '0, '0, '0, '0, '0);
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        is_vector    = 1'b0;
        is_store     = 1'b0;
        vec_mode     = lsu_pkg::VEC_UNIT;
        vec_stride   = '0;
        vec_index    = '0;
        addr         = '0;
        write_data   = '0;
        dest_reg_idx = '0;
        global_req_ready  = 1'b1;
        global_resp_valid = 1'b0;
        global_resp_rd    = '0;
        global_resp_data  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        #(CLK_PERIOD / 4);

        errs = errors;
        check_value("global_req_valid", global_req_valid, 1'b0);
        check_value("wb_valid", wb_valid, 1'b0);
        check_value("stall_pipeline", stall_pipeline, 1'b0);
        check_value("busy", busy, 1'b0);
        finish_test("reset", errs);

        // Upper lanes of the store data must not reach the load result
        errs = errors;
        pend_ops.push_back(make_op(1'b0, 1'b1, lsu_pkg::VEC_UNIT, '0, '0, 32'h1100,
                                   {96'hdead_beef_0bad_f00d_1234_5678, 32'hcafe_f00d}, 5'd3));
        pend_ops.push_back(make_op(1'b0, 1'b0, lsu_pkg::VEC_UNIT, '0, '0, 32'h1100,
                                   '0, 5'd7));
        run_ops();
        finish_test("scalar store then load", errs);

        errs = errors;
        pend_ops.push_back(make_op(1'b1, 1'b1, lsu_pkg::VEC_UNIT, '0, '0, 32'h120b,
                                   128'h4444_4444_3333_3333_2222_2222_1111_1111, 5'd1));
        pend_ops.push_back(make_op(1'b1, 1'b0, lsu_pkg::VEC_UNIT, '0, '0, 32'h1207,
                                   '0, 5'd12));
        run_ops();
        finish_test("vector unit store then load", errs);

        errs = errors;
        pend_ops.push_back(make_op(1'b1, 1'b1, lsu_pkg::VEC_STRIDE, 32'h24, '0, 32'h1404,
                                   128'hd0d0_0004_c0c0_0003_b0b0_0002_a0a0_0001, 5'd2));
        pend_ops.push_back(make_op(1'b1, 1'b0, lsu_pkg::VEC_STRIDE, 32'h24, '0, 32'h1404,
                                   '0, 5'd20));
        pend_ops.push_back(make_op(1'b1, 1'b1, lsu_pkg::VEC_INDEXED, '0,
                                   {32'h14, 32'h100, 32'h8, 32'h3c}, 32'h1310,
                                   128'h0404_4040_0303_3030_0202_2020_0101_1010, 5'd4));
        pend_ops.push_back(make_op(1'b1, 1'b0, lsu_pkg::VEC_INDEXED, '0,
                                   {32'h14, 32'h100, 32'h8, 32'h3c}, 32'h1310, '0, 5'd31));
        run_ops();
        finish_test("strided and indexed vectors", errs);

        errs = errors;
        random_ready = 1'b1;  // Ready gaps on the global port
        for (int i = 0; i < N_RANDOM; i++) begin
            pend_ops.push_back(random_op());
        end
        run_ops();
        finish_test("random mix", errs);

        errs = errors;
        check_value("busy", busy, 1'b0);
        check_value("writeback count", wb_count, loads_issued);
        finish_test("drain", errs);

        $display("Tests %0d, checks %0d, errors %0d, loads %0d, writebacks %0d",
                 tests, checks, errors, loads_issued, wb_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_global.f */
logic/lsu_pkg.sv
logic/lsu_req_if.sv
logic/lsu_decode.sv
logic/lsu_beat_seq.sv
logic/lsu_resp_collect.sv
logic/lsu_global.sv
test/lsu_global_asserts.sv
test/lsu_global_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_global_tb -f lsu_global.f -o lsu_global_sim || exit 1

# Pass only when the testbench prints its pass line
result=$(./obj_dir/lsu_global_sim)
echo "$result"
echo "$result" | grep -qxF '** PASS **' && exit 0 || exit 1
